// ==== cpu_pkg.sv ====
// cpu shared definitions: widths, memory-mapped addresses, opcodes, alu operations, states
`default_nettype none

package cpu_pkg;

    // data and address width
    localparam int xlen = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs = 32;

    // memory-mapped stores
    localparam logic [xlen-1:0] out_port_addr = 32'd1000;
    localparam logic [xlen-1:0] halt_addr = 32'd1004;

    // funct3 codes of the OP group
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll = 3'b001;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // funct3 codes of branches and word accesses
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;

    // funct7 codes, alt selects SUB and SRA
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    typedef enum logic [6:0] {
        LOAD = 7'b0000011,
        STORE = 7'b0100011,
        BRANCH = 7'b1100011,
        OP_IMM = 7'b0010011,
        OP = 7'b0110011,
        LUI = 7'b0110111,
        AUIPC = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INSTR,
        WAIT_MEM,
        HALTED
    } state_e;

endpackage

`default_nettype wire

// ==== reg_file.sv ====
// 32x32 register file, two asynchronous reads, one synchronous write, x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [reg_sel_width-1:0] rs1_sel,
    input  wire logic [reg_sel_width-1:0] rs2_sel,
    input  wire logic                     wr_en,
    input  wire logic [reg_sel_width-1:0] wr_sel,
    input  wire logic [xlen-1:0]          wr_data,
    output logic [xlen-1:0]               rs1_data,
    output logic [xlen-1:0]               rs2_data
);

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 is never written, so it keeps its reset value
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

endmodule

`default_nettype wire

// ==== int_alu.sv ====
// integer alu for OP and OP-IMM instructions, with the branch equality flag
`timescale 1ns/1ps
`default_nettype none

module int_alu import cpu_pkg::*; (
    input  wire alu_op_e         alu_op,
    input  wire logic [xlen-1:0] rs1_data,
    input  wire logic [xlen-1:0] rs2_data,
    input  wire logic [xlen-1:0] imm,
    input  wire logic            uses_imm,
    output logic [xlen-1:0]      alu_result,
    output logic                 equal
);

    logic [xlen-1:0] operand_b;
    logic [4:0]      shamt;

    assign operand_b = uses_imm ? imm : rs2_data;
    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = rs1_data + operand_b;
            ALU_SUB: alu_result = rs1_data - operand_b;
            ALU_AND: alu_result = rs1_data & operand_b;
            ALU_OR: alu_result = rs1_data | operand_b;
            ALU_XOR: alu_result = rs1_data ^ operand_b;
            ALU_SLL: alu_result = rs1_data << shamt;
            ALU_SRL: alu_result = rs1_data >> shamt;
            // sign bit fills from the left
            ALU_SRA: alu_result = $unsigned($signed(rs1_data) >>> shamt);
            ALU_SLT: alu_result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            ALU_SLTU: alu_result = {31'b0, rs1_data < operand_b};
            ALU_PASS_B: alu_result = operand_b;
            default: alu_result = '0;
        endcase
    end

    // branches always compare the two registers
    assign equal = (rs1_data == rs2_data);

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
// instruction decoder: fields, sign-extended immediates and alu operation select
`timescale 1ns/1ps
`default_nettype none

module instr_decode import cpu_pkg::*; (
    input  wire logic [xlen-1:0]     instr,
    output opcode_e                  opcode,
    output logic [2:0]               funct3,
    output logic [reg_sel_width-1:0] rd_sel,
    output logic [reg_sel_width-1:0] rs1_sel,
    output logic [reg_sel_width-1:0] rs2_sel,
    output logic [xlen-1:0]          imm,
    output alu_op_e                  alu_op,
    output logic                     uses_imm,
    output logic                     illegal
);

    logic [6:0]      funct7;
    logic [xlen-1:0] i_imm;
    logic [xlen-1:0] s_imm;
    logic [xlen-1:0] b_imm;
    logic [xlen-1:0] u_imm;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd_sel = instr[11:7];
    assign rs1_sel = instr[19:15];
    assign rs2_sel = instr[24:20];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // branch offsets are in bytes with bit 0 always clear
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};

    always_comb begin
        imm = '0;
        alu_op = ALU_ADD;
        uses_imm = 1'b0;
        illegal = 1'b0;
        case (opcode)
            LOAD: begin
                imm = i_imm;
                illegal = (funct3 != f3_word);
            end
            STORE: begin
                imm = s_imm;
                illegal = (funct3 != f3_word);
            end
            BRANCH: begin
                imm = b_imm;
                illegal = (funct3 != f3_beq) && (funct3 != f3_bne);
            end
            OP_IMM: begin
                // only ADDI is supported
                imm = i_imm;
                uses_imm = 1'b1;
                illegal = (funct3 != f3_add_sub);
            end
            OP: begin
                // alt funct7 is only valid for SUB and SRA
                illegal = (funct7 != f7_base)
                          && !((funct7 == f7_alt)
                               && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
                case (funct3)
                    f3_add_sub: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    f3_sll: alu_op = ALU_SLL;
                    f3_slt: alu_op = ALU_SLT;
                    f3_sltu: alu_op = ALU_SLTU;
                    f3_xor: alu_op = ALU_XOR;
                    f3_srl_sra: alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    f3_or: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            LUI: begin
                imm = u_imm;
                uses_imm = 1'b1;
                alu_op = ALU_PASS_B;
            end
            AUIPC: imm = u_imm;
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== cpu_control.sv ====
// core control: fetch/execute/memory fsm, program counter, branches and memory requests
`timescale 1ns/1ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic [xlen-1:0]          mem_rd_data,
    input  wire logic                     mem_ack,
    input  wire opcode_e                  opcode,
    input  wire logic [2:0]               funct3,
    input  wire logic [reg_sel_width-1:0] rd_sel,
    input  wire logic [xlen-1:0]          imm,
    input  wire logic                     illegal,
    input  wire logic [xlen-1:0]          rs1_data,
    input  wire logic [xlen-1:0]          rs2_data,
    input  wire logic [xlen-1:0]          alu_result,
    input  wire logic                     equal,
    output logic [xlen-1:0]               instr,
    output logic [xlen-1:0]               mem_addr,
    output logic [xlen-1:0]               mem_wr_data,
    output logic                          mem_rd_req,
    output logic                          mem_wr_req,
    output logic                          wr_en,
    output logic [reg_sel_width-1:0]      wr_sel,
    output logic [xlen-1:0]               wr_data,
    output logic [xlen-1:0]               out_data,
    output logic                          out_valid,
    output logic                          halt
);

    state_e                   state;
    logic [xlen-1:0]          pc;
    logic                     instr_ready;
    logic                     load_pending;
    logic [reg_sel_width-1:0] load_rd;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_rel;
    logic [xlen-1:0] data_addr;
    logic [xlen-1:0] next_pc;
    logic            branch_taken;
    logic            exec;
    logic            instr_ack;
    logic            mem_done;
    logic            do_load;
    logic            do_store;
    logic            do_out;
    logic            do_halt;

    assign pc_plus4 = pc + 32'd4;
    // shared by branch targets and auipc
    assign pc_rel = pc + imm;
    assign data_addr = rs1_data + imm;

    assign branch_taken = (opcode == BRANCH) && ((funct3 == f3_bne) ? !equal : equal);
    assign next_pc = branch_taken ? pc_rel : pc_plus4;

    // instruction executes the cycle after its ack
    assign exec = (state == WAIT_INSTR) && instr_ready;
    assign instr_ack = (state == WAIT_INSTR) && !instr_ready && mem_ack;
    assign mem_done = (state == WAIT_MEM) && mem_ack;

    assign do_load = exec && !illegal && (opcode == LOAD);
    assign do_out = exec && !illegal && (opcode == STORE) && (data_addr == out_port_addr);
    assign do_store = exec && !illegal && (opcode == STORE)
                      && (data_addr != out_port_addr) && (data_addr != halt_addr);
    // unknown opcodes stop the core too
    assign do_halt = exec && (illegal || ((opcode == STORE) && (data_addr == halt_addr)));

    // register write-back source
    always_comb begin
        wr_en = 1'b0;
        wr_sel = rd_sel;
        wr_data = alu_result;
        if (exec && !illegal) begin
            case (opcode)
                OP, OP_IMM, LUI: wr_en = 1'b1;
                AUIPC: begin
                    wr_en = 1'b1;
                    wr_data = pc_rel;
                end
                default: wr_en = 1'b0;
            endcase
        end else if (mem_done && load_pending) begin
            wr_en = 1'b1;
            wr_sel = load_rd;
            wr_data = mem_rd_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
            pc <= '0;
            instr_ready <= 1'b0;
            load_pending <= 1'b0;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_valid <= 1'b0;
            halt <= 1'b0;
        end else begin
            // requests and output strobes are single-cycle pulses
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_valid <= 1'b0;
            case (state)
                FETCH: begin
                    mem_rd_req <= 1'b1;
                    state <= WAIT_INSTR;
                end
                WAIT_INSTR: begin
                    if (instr_ack) begin
                        instr_ready <= 1'b1;
                    end else if (exec) begin
                        instr_ready <= 1'b0;
                        if (do_halt) begin
                            halt <= 1'b1;
                            state <= HALTED;
                        end else if (do_load || do_store) begin
                            mem_rd_req <= do_load;
                            mem_wr_req <= do_store;
                            load_pending <= do_load;
                            state <= WAIT_MEM;
                        end else begin
                            out_valid <= do_out;
                            pc <= next_pc;
                            state <= FETCH;
                        end
                    end
                end
                WAIT_MEM: begin
                    if (mem_done) begin
                        load_pending <= 1'b0;
                        pc <= pc_plus4;
                        state <= FETCH;
                    end
                end
                default: state <= HALTED;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (instr_ack) begin
            instr <= mem_rd_data;
        end
        if (state == FETCH) begin
            mem_addr <= pc;
        end else if (do_load || do_store) begin
            mem_addr <= data_addr;
            mem_wr_data <= rs2_data;
            load_rd <= rd_sel;
        end
        if (do_out) begin
            out_data <= rs2_data;
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
// multicycle rv32i core: control, decode, register file and alu on one memory port
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    output logic [xlen-1:0]        mem_addr,
    output logic [xlen-1:0]        mem_wr_data,
    input  wire logic [xlen-1:0]   mem_rd_data,
    output logic                   mem_rd_req,
    output logic                   mem_wr_req,
    input  wire logic              mem_ack,
    output logic [xlen-1:0]        out_data,
    output logic                   out_valid,
    output logic                   halt
);

    logic [xlen-1:0]          instr;
    opcode_e                  opcode;
    logic [2:0]               funct3;
    logic [reg_sel_width-1:0] rd_sel;
    logic [reg_sel_width-1:0] rs1_sel;
    logic [reg_sel_width-1:0] rs2_sel;
    logic [xlen-1:0]          imm;
    alu_op_e                  alu_op;
    logic                     uses_imm;
    logic                     illegal;
    logic [xlen-1:0]          rs1_data;
    logic [xlen-1:0]          rs2_data;
    logic                     wr_en;
    logic [reg_sel_width-1:0] wr_sel;
    logic [xlen-1:0]          wr_data;
    logic [xlen-1:0]          alu_result;
    logic                     equal;

    cpu_control u_control (
        .clk        (clk),
        .rst        (rst),
        .mem_rd_data(mem_rd_data),
        .mem_ack    (mem_ack),
        .opcode     (opcode),
        .funct3     (funct3),
        .rd_sel     (rd_sel),
        .imm        (imm),
        .illegal    (illegal),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .equal      (equal),
        .instr      (instr),
        .mem_addr   (mem_addr),
        .mem_wr_data(mem_wr_data),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halt       (halt)
    );

    instr_decode u_decode (
        .instr   (instr),
        .opcode  (opcode),
        .funct3  (funct3),
        .rd_sel  (rd_sel),
        .rs1_sel (rs1_sel),
        .rs2_sel (rs2_sel),
        .imm     (imm),
        .alu_op  (alu_op),
        .uses_imm(uses_imm),
        .illegal (illegal)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .rs1_sel (rs1_sel),
        .rs2_sel (rs2_sel),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    int_alu u_alu (
        .alu_op    (alu_op),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .uses_imm  (uses_imm),
        .alu_result(alu_result),
        .equal     (equal)
    );

endmodule

`default_nettype wire

// ==== cpu_core_props.sv ====
// protocol assertions for the cpu core: reset quiet, one request at a time, sticky halt
`timescale 1ns/1ps
`default_nettype none

module cpu_core_props (
    input wire logic clk,
    input wire logic rst,
    input wire logic mem_rd_req,
    input wire logic mem_wr_req,
    input wire logic mem_ack,
    input wire logic out_valid,
    input wire logic halt
);

    int   prop_fails = 0;
    logic outstanding;

    // a request stays outstanding up to and including its ack cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= 1'b0;
        end else if (mem_rd_req || mem_wr_req) begin
            outstanding <= 1'b1;
        end else if (mem_ack) begin
            outstanding <= 1'b0;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (rst || $past(rst)) |-> !(mem_rd_req || mem_wr_req || out_valid || halt))
        else begin
            $error("request, output or halt active during or right after reset");
            prop_fails++;
        end

    no_dual_request: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req))
        else begin
            $error("read and write requested in the same cycle");
            prop_fails++;
        end

    single_outstanding: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !(mem_rd_req || mem_wr_req))
        else begin
            $error("new memory request while one is still outstanding");
            prop_fails++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
        else begin
            $error("halt dropped before reset");
            prop_fails++;
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (rst)
        halt |-> !(mem_rd_req || mem_wr_req))
        else begin
            $error("memory request after halt");
            prop_fails++;
        end

endmodule

bind cpu_core cpu_core_props u_props (
    .clk       (clk),
    .rst       (rst),
    .mem_rd_req(mem_rd_req),
    .mem_wr_req(mem_wr_req),
    .mem_ack   (mem_ack),
    .out_valid (out_valid),
    .halt      (halt)
);

`default_nettype wire

// ==== tb_clock.sv ====
// testbench clock and reset: 8 ns clock, reset held high for the first 10 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release lands just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
// testbench top: memory model with random ack delay, program image, output checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();

    logic        clk;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic [31:0] mem_rd_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic        mem_ack;
    logic [31:0] out_data;
    logic        out_valid;
    logic        halt;

    logic [31:0] mem [256];
    logic [31:0] exp_out [$];
    logic [31:0] exp_store_addr [$];
    logic [31:0] exp_store_data [$];
    string       test_names [$];
    int          test_last [$];
    int          load_idx = 0;
    int          out_count = 0;
    int          store_count = 0;
    int          test_idx = 0;
    int          errors = 0;
    integer      seed = 32'h350e;

    tb_clock u_clock (
        .clk(clk),
        .rst(rst)
    );

    cpu_core u_dut (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_wr_data(mem_wr_data),
        .mem_rd_data(mem_rd_data),
        .mem_rd_req (mem_rd_req),
        .mem_wr_req (mem_wr_req),
        .mem_ack    (mem_ack),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .halt       (halt)
    );

    // rv32i encoders, register numbers and immediates as plain integers
    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3_add_sub, 5'(rd), OP_IMM};
    endfunction

    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3_word, 5'(rd), LOAD};
    endfunction

    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), f3_word, s[4:0], STORE};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP};
    endfunction

    function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1, input int rs2,
                                           input int offset);
        logic [12:0] b;
        b = 13'(offset);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], BRANCH};
    endfunction

    function automatic logic [31:0] upper(input opcode_e opc, input int rd, input int imm20);
        return {20'(imm20), 5'(rd), opc};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[load_idx] = word;
        load_idx++;
    endtask

    // store a register to the output port and note the word it must carry
    task automatic emit_out(input int rs, input logic [31:0] value);
        emit(sw(rs, 0, int'(out_port_addr)));
        exp_out.push_back(value);
    endtask

    task automatic emit_store(input int rs2, input int rs1, input int imm,
                              input logic [31:0] addr, input logic [31:0] value);
        emit(sw(rs2, rs1, imm));
        exp_store_addr.push_back(addr);
        exp_store_data.push_back(value);
    endtask

    task automatic end_test(input string name);
        test_names.push_back(name);
        test_last.push_back(exp_out.size() - 1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, want, got);
            errors++;
        end
    endtask

    initial begin : program_image
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hd47a0000 | 32'(i * 4);
        end
        // operands x1 = 7, x2 = -3, x4 = 0x80000000
        emit(addi(1, 0, 7));
        emit(addi(2, 0, -3));
        emit(upper(LUI, 4, 32'h80000));
        emit_out(1, 32'd7);
        emit(r_type(f7_base, f3_add_sub, 3, 1, 2));
        emit_out(3, 32'd4);
        emit(r_type(f7_alt, f3_add_sub, 3, 2, 1));
        emit_out(3, 32'hfffffff6);
        emit(r_type(f7_base, f3_and, 3, 1, 2));
        emit_out(3, 32'h00000005);
        emit(r_type(f7_base, f3_or, 3, 1, 2));
        emit_out(3, 32'hffffffff);
        emit(r_type(f7_base, f3_xor, 3, 1, 2));
        emit_out(3, 32'hfffffffa);
        emit(r_type(f7_base, f3_sll, 3, 2, 1));
        emit_out(3, 32'hfffffe80);
        emit(r_type(f7_base, f3_srl_sra, 3, 2, 1));
        emit_out(3, 32'h01ffffff);
        emit(r_type(f7_alt, f3_srl_sra, 3, 4, 1));
        emit_out(3, 32'hff000000);
        emit(r_type(f7_base, f3_slt, 3, 2, 1));
        emit_out(3, 32'd1);
        emit(r_type(f7_base, f3_sltu, 3, 2, 1));
        emit_out(3, 32'd0);
        end_test("alu");
        emit_out(4, 32'h80000000);
        // auipc sits at byte 100
        emit(upper(AUIPC, 5, 1));
        emit_out(5, 32'h00001064);
        emit(addi(0, 1, 5));
        emit_out(0, 32'd0);
        end_test("upper");
        // countdown loop from 5, x7 counts the passes
        emit(addi(6, 0, 5));
        emit(addi(6, 6, -1));
        emit(addi(7, 7, 1));
        emit(branch(f3_bne, 6, 0, -8));
        emit_out(6, 32'd0);
        emit_out(7, 32'd5);
        emit(addi(8, 0, 32'h111));
        emit(branch(f3_beq, 1, 1, 8));
        emit(addi(8, 0, 32'h333));
        emit_out(8, 32'h111);
        emit(branch(f3_beq, 1, 2, 8));
        emit(addi(8, 0, 32'h222));
        emit_out(8, 32'h222);
        end_test("branch");
        // data region around 0x200
        emit(addi(9, 0, 512));
        emit_store(2, 9, 0, 32'h200, 32'hfffffffd);
        emit_store(4, 9, 4, 32'h204, 32'h80000000);
        emit_store(1, 9, -4, 32'h1fc, 32'd7);
        emit(lw(10, 9, 4));
        emit_out(10, 32'h80000000);
        emit(lw(11, 9, 0));
        emit_out(11, 32'hfffffffd);
        emit(lw(12, 9, -4));
        emit_out(12, 32'd7);
        end_test("memory");
        emit(sw(0, 0, int'(halt_addr)));
        // never reached once the core halts
        emit(sw(1, 0, int'(out_port_addr)));
    end

    // one request at a time, acked 1 to 4 cycles later
    initial begin : memory_model
        int          delay;
        logic [31:0] addr;
        mem_ack = 1'b0;
        mem_rd_data = '0;
        forever begin
            @(negedge clk);
            if (!rst && (mem_rd_req || mem_wr_req)) begin
                addr = mem_addr;
                if (mem_wr_req) begin
                    assert (store_count < exp_store_addr.size()) else begin
                        $display("%0t: store to %h that the program never makes", $time, addr);
                        errors++;
                    end
                    if (store_count < exp_store_addr.size()) begin
                        check_word("mem_addr", addr, exp_store_addr[store_count]);
                        check_word("mem_wr_data", mem_wr_data, exp_store_data[store_count]);
                    end
                    store_count++;
                    mem[addr[9:2]] = mem_wr_data;
                end
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(posedge clk);
                #1;
                mem_ack = 1'b1;
                mem_rd_data = mem[addr[9:2]];
                @(posedge clk);
                #1;
                mem_ack = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            assert (out_count < exp_out.size()) else begin
                $display("%0t: output word %h came after the last expected one", $time, out_data);
                errors++;
            end
            if (out_count < exp_out.size()) begin
                check_word("out_data", out_data, exp_out[out_count]);
                if (test_idx < test_last.size() && out_count == test_last[test_idx]) begin
                    $display("test %s done: %0d outputs, %0d errors so far",
                             test_names[test_idx], out_count + 1, errors);
                    test_idx++;
                end
            end
            out_count++;
        end
    end

    initial begin : main
        wait (halt === 1'b1);
        assert (out_count == exp_out.size()) else begin
            $display("halt rose after %0d of %0d expected output words", out_count, exp_out.size());
            errors++;
        end
        // stay a while to catch anything after halt
        repeat (20) @(posedge clk);
        $display("test halt done: halted after %0d outputs, %0d errors so far", out_count, errors);
        $display("%0d tests, %0d outputs, %0d stores, %0d errors, %0d property failures",
                 test_idx + 1, out_count, store_count, errors, u_dut.u_props.prop_fails);
        if (errors == 0 && u_dut.u_props.prop_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // about 65 executed instructions of at most 12 cycles, five times over
    initial begin : watchdog
        repeat (65 * 12 * 5) @(posedge clk);
        $display("timeout: the core never halted within %0d cycles", 65 * 12 * 5);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_core.f ====
cpu_pkg.sv
reg_file.sv
int_alu.sv
instr_decode.sv
cpu_control.sv
cpu_core.sv
cpu_core_props.sv
tb_clock.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_core testbench with verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f cpu_core.f --top-module tb_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_top +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$log"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$log"; then
    echo "no result line found in $log"
    exit 1
fi
exit 0
